//--- sim.f
rtl/ctn_pkg.sv
rtl/power_on_seq.sv
rtl/ctn_arbiter.sv
rtl/ctn_sram_adapter.sv
rtl/ctn_ram.sv
rtl/ctn_top.sv
test/ctn_checker.sv
test/ctn_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds ctn_tb with Verilator, runs it and searches the log for the fail message
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module ctn_tb -Mdir obj_dir > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vctn_tb +verilator+error+limit+100 > sim.log 2>&1
status=$?
cat sim.log

if grep -q '\*\* FAIL \*\*' sim.log; then
  echo "Simulation reported failure"
  exit 1
fi
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi
echo "Simulation completed without failure"
exit 0

//--- test/ctn_tb.sv
// Random two-host traffic on ctn_top, checked against a word model of the RAM
// Outputs are sampled at the falling edge, inputs change 1 ns after the rising edge
`timescale 1ns/1ps

module ctn_tb;
  import ctn_pkg::*;

  localparam int NumTxn    = 200; // Acceptances per host
  localparam int PorCycles = 20;  // Edges from reset release to por_n_o
  localparam int ClkPeriod = 10;

  logic                clk_aon = 1'b0;
  logic                arst_n_i;
  logic [NumHosts-1:0] valid;
  logic [NumHosts-1:0] we;
  ctn_addr_u           addr [NumHosts];
  logic [CtnDw-1:0]    wdata [NumHosts];
  logic [CtnBw-1:0]    be [NumHosts];
  wire  [NumHosts-1:0] ready;
  wire  [NumHosts-1:0] rsp_valid;
  wire  [NumHosts-1:0] rsp_err;
  wire  [CtnDw-1:0]    rsp_rdata [NumHosts];
  wire                 por_n;

  // Model state
  logic [CtnDw-1:0]    mem_m [int];
  int                  due_q [$];
  logic                host_q [$];
  logic                err_q [$];
  logic [CtnDw-1:0]    data_q [$];
  integer              seed = 32'hc2f15bda;
  int                  cyc = 0;          // Number of the next rising edge after reset release
  int                  n_acc [NumHosts] = '{0, 0};
  logic                last_acc = 1'b1;  // Host 1 counts as last after reset
  logic [NumHosts-1:0] acc = '0;

  ctn_top dut_i (
    .clk_aon        (clk_aon),
    .arst_n_i       (arst_n_i),
    .h0_req_valid_i (valid[0]),
    .h0_we_i        (we[0]),
    .h0_addr_i      (addr[0]),
    .h0_wdata_i     (wdata[0]),
    .h0_be_i        (be[0]),
    .h0_req_ready_o (ready[0]),
    .h0_rsp_valid_o (rsp_valid[0]),
    .h0_rsp_rdata_o (rsp_rdata[0]),
    .h0_rsp_err_o   (rsp_err[0]),
    .h1_req_valid_i (valid[1]),
    .h1_we_i        (we[1]),
    .h1_addr_i      (addr[1]),
    .h1_wdata_i     (wdata[1]),
    .h1_be_i        (be[1]),
    .h1_req_ready_o (ready[1]),
    .h1_rsp_valid_o (rsp_valid[1]),
    .h1_rsp_rdata_o (rsp_rdata[1]),
    .h1_rsp_err_o   (rsp_err[1]),
    .por_n_o        (por_n)
  );

  always #(ClkPeriod / 2) clk_aon = ~clk_aon;

  task automatic check_val(input string name, input logic [31:0] exp_v,
                           input logic [31:0] act_v);
    if (act_v !== exp_v) begin
      $display("[ERROR] %0t %s expected %h actual %h", $time, name, exp_v, act_v);
      $display("** FAIL **");
      $fatal(1, "Value mismatch on %s", name);
    end
  endtask

  task automatic new_request(input int h);
    logic [31:0] r;
    r           = $random(seed);
    valid[h]    = (r[1:0] != 2'b00); // Idle about a quarter of the time
    we[h]       = r[2];
    // About 70% of requests hit one of eight RAM words
    addr[h].fields.region = (r[13:4] < 10'd717) ? RamRegion :
                            (r[31:24] == RamRegion) ? (r[31:24] ^ 8'h01) : r[31:24];
    addr[h].fields.idx    = {5'b0, r[16:14]};
    be[h]       = r[20:17];
    wdata[h]    = $random(seed);
  endtask

  task automatic record_accept(input int h);
    int               idx;
    logic [CtnDw-1:0] word;
    idx  = int'(addr[h].fields.idx);
    word = '0;
    if (mem_m.exists(idx)) begin
      word = mem_m[idx];
    end
    due_q.push_back(cyc + RamLatency);
    host_q.push_back(h == 1);
    if (addr[h].fields.region != RamRegion) begin
      err_q.push_back(1'b1); // Decode error, RAM untouched
      data_q.push_back(CtnDw'(0));
    end else if (we[h]) begin
      for (int b = 0; b < CtnBw; b++) begin
        if (be[h][b]) begin
          word[8*b +: 8] = wdata[h][8*b +: 8];
        end
      end
      mem_m[idx] = word;
      err_q.push_back(1'b0);
      data_q.push_back(CtnDw'(0));
    end else begin
      err_q.push_back(1'b0);
      data_q.push_back(word);
    end
    last_acc = (h == 1);
    n_acc[h]++;
  endtask

  task automatic check_cycle();
    logic                por_exp;
    logic [NumHosts-1:0] rdy_exp;
    logic [NumHosts-1:0] vld_exp;
    int                  h;
    por_exp = (cyc > PorCycles);
    check_val("por_n_o", 32'(por_exp), 32'(por_n));
    // The host not accepted last wins a tie
    rdy_exp = '0;
    if (por_exp && valid[0] && (!valid[1] || last_acc)) begin
      rdy_exp[0] = 1'b1;
    end else if (por_exp && valid[1]) begin
      rdy_exp[1] = 1'b1;
    end
    check_val("req_ready_o", 32'(rdy_exp), 32'(ready));
    vld_exp = '0;
    if (due_q.size() > 0 && due_q[0] == cyc) begin
      h = host_q[0] ? 1 : 0;
      vld_exp[h] = 1'b1;
      check_val(h == 1 ? "h1_rsp_rdata_o" : "h0_rsp_rdata_o", data_q[0], rsp_rdata[h]);
      check_val(h == 1 ? "h1_rsp_err_o" : "h0_rsp_err_o", 32'(err_q[0]), 32'(rsp_err[h]));
      void'(due_q.pop_front());
      void'(host_q.pop_front());
      void'(err_q.pop_front());
      void'(data_q.pop_front());
    end
    check_val("rsp_valid_o", 32'(vld_exp), 32'(rsp_valid));
    acc = valid & ready; // Accepted at the coming rising edge
    for (int i = 0; i < NumHosts; i++) begin
      if (acc[i]) begin
        record_accept(i);
      end
    end
  endtask

  always @(negedge clk_aon) begin
    if (arst_n_i) begin
      cyc++;
    end
    check_cycle();
  end

  initial begin
    arst_n_i = 1'b0;
    for (int h = 0; h < NumHosts; h++) begin
      new_request(h);
    end
    valid = '1; // Both hosts wait for power-on
    repeat (10) @(posedge clk_aon);
    #1 arst_n_i = 1'b1;
    while (n_acc[0] < NumTxn || n_acc[1] < NumTxn || due_q.size() > 0) begin
      @(posedge clk_aon);
      #1;
      for (int h = 0; h < NumHosts; h++) begin
        if (acc[h] || !valid[h]) begin
          if (n_acc[h] < NumTxn) begin
            new_request(h);
          end else begin
            valid[h] = 1'b0;
          end
        end
      end
    end
    repeat (2) @(posedge clk_aon);
    if (!dut_i.u_checker.failed) begin
      $display("** PASS **");
    end else begin
      $display("Bound assertion failed during the run");
      $display("** FAIL **");
    end
    $finish;
  end

  // Stop at the first bound assertion failure
  always @(posedge dut_i.u_checker.failed) begin
    $display("Bound assertion failed during the run");
    $display("** FAIL **");
    $fatal(1, "Assertion failure in ctn_checker");
  end

  // Watchdog
  initial begin
    #((NumTxn * NumHosts * 20 + PorCycles + 10) * ClkPeriod);
    $display("Timeout: traffic did not complete in time");
    $display("** FAIL **");
    $fatal(1, "Watchdog timeout");
  end

endmodule

//--- test/ctn_checker.sv
// Assertions on the CTN host ports, bound into every ctn_top
// Checks are idle while arst_n_i is low
`timescale 1ns/1ps

module ctn_checker (
  input logic clk_aon,
  input logic arst_n_i,
  input logic h0_req_valid_i,
  input logic h0_req_ready_o,
  input logic h0_rsp_valid_o,
  input logic h1_req_valid_i,
  input logic h1_req_ready_o,
  input logic h1_rsp_valid_o,
  input logic por_n_o
);
  import ctn_pkg::*;

  logic excl_fail = 1'b0;
  logic por_fail  = 1'b0;
  logic lat0_fail = 1'b0;
  logic lat1_fail = 1'b0;
  logic failed;

  assign failed = excl_fail | por_fail | lat0_fail | lat1_fail;

  // At most one grant per cycle
  ready_onehot_a: assert property (@(posedge clk_aon) disable iff (!arst_n_i)
    !(h0_req_ready_o && h1_req_ready_o))
    else begin
      excl_fail = 1'b1;
      $error("Both ready outputs are high in the same cycle");
    end

  ready_por_a: assert property (@(posedge clk_aon) disable iff (!arst_n_i)
    !por_n_o |-> (!h0_req_ready_o && !h1_req_ready_o))
    else begin
      por_fail = 1'b1;
      $error("Ready is high while por_n_o is low");
    end

  ////////////////////////////////////////
  // Fixed response latency per host
  ////////////////////////////////////////

  h0_latency_a: assert property (@(posedge clk_aon) disable iff (!arst_n_i)
    (h0_req_valid_i && h0_req_ready_o) |-> ##RamLatency h0_rsp_valid_o)
    else begin
      lat0_fail = 1'b1;
      $error("Host 0 response missing two cycles after acceptance");
    end

  h1_latency_a: assert property (@(posedge clk_aon) disable iff (!arst_n_i)
    (h1_req_valid_i && h1_req_ready_o) |-> ##RamLatency h1_rsp_valid_o)
    else begin
      lat1_fail = 1'b1;
      $error("Host 1 response missing two cycles after acceptance");
    end

endmodule

bind ctn_top ctn_checker u_checker (.*);

//--- rtl/ctn_top.sv
// CTN memory path with its power-on sequence, all on clk_aon
// Read data is shared by both hosts, only rsp_valid tells whose it is
`timescale 1ns/1ps

module ctn_top (
  input  logic                      clk_aon,
  input  logic                      arst_n_i,
  // Host 0
  input  logic                      h0_req_valid_i,
  input  logic                      h0_we_i,
  input  ctn_pkg::ctn_addr_u        h0_addr_i,
  input  logic [ctn_pkg::CtnDw-1:0] h0_wdata_i,
  input  logic [ctn_pkg::CtnBw-1:0] h0_be_i,
  output logic                      h0_req_ready_o,
  output logic                      h0_rsp_valid_o,
  output logic [ctn_pkg::CtnDw-1:0] h0_rsp_rdata_o,
  output logic                      h0_rsp_err_o,
  // Host 1
  input  logic                      h1_req_valid_i,
  input  logic                      h1_we_i,
  input  ctn_pkg::ctn_addr_u        h1_addr_i,
  input  logic [ctn_pkg::CtnDw-1:0] h1_wdata_i,
  input  logic [ctn_pkg::CtnBw-1:0] h1_be_i,
  output logic                      h1_req_ready_o,
  output logic                      h1_rsp_valid_o,
  output logic [ctn_pkg::CtnDw-1:0] h1_rsp_rdata_o,
  output logic                      h1_rsp_err_o,
  output logic                      por_n_o
);
  import ctn_pkg::*;

  logic              por_ok;
  // Merged request
  logic              req;
  logic              we;
  ctn_addr_u         addr;
  logic [CtnDw-1:0]  wdata;
  logic [CtnBw-1:0]  be;
  logic              host;
  // RAM port
  logic              ram_req;
  logic              ram_we;
  logic [SramAw-1:0] ram_addr;
  logic [CtnDw-1:0]  ram_wdata;
  logic [CtnBw-1:0]  ram_be;
  logic              ram_rvalid;
  logic [CtnDw-1:0]  ram_rdata;
  // Shared response
  logic [CtnDw-1:0]  rsp_rdata;
  logic              rsp_err;

  ////////////////////////////////////////
  // Power-on and arbitration
  ////////////////////////////////////////

  power_on_seq u_por (
    .clk_aon,
    .arst_n_i,
    .por_n_o (por_ok)
  );

  assign por_n_o = por_ok;

  ctn_arbiter u_arb (
    .clk_aon,
    .arst_n_i,
    .por_n_i     (por_ok),
    .req_valid_i ({h1_req_valid_i, h0_req_valid_i}),
    .we_i        ({h1_we_i, h0_we_i}),
    .addr_i      ({h1_addr_i, h0_addr_i}),
    .wdata_i     ({h1_wdata_i, h0_wdata_i}),
    .be_i        ({h1_be_i, h0_be_i}),
    .req_ready_o ({h1_req_ready_o, h0_req_ready_o}),
    .req_o       (req),
    .we_o        (we),
    .addr_o      (addr),
    .wdata_o     (wdata),
    .be_o        (be),
    .host_o      (host)
  );

  ////////////////////////////////////////
  // Adapter and RAM
  ////////////////////////////////////////

  ctn_sram_adapter u_adapter (
    .clk_aon,
    .arst_n_i,
    .req_i        (req),
    .we_i         (we),
    .addr_i       (addr),
    .wdata_i      (wdata),
    .be_i         (be),
    .host_i       (host),
    .ram_req_o    (ram_req),
    .ram_we_o     (ram_we),
    .ram_addr_o   (ram_addr),
    .ram_wdata_o  (ram_wdata),
    .ram_be_o     (ram_be),
    .ram_rvalid_i (ram_rvalid),
    .ram_rdata_i  (ram_rdata),
    .rsp_valid_o  ({h1_rsp_valid_o, h0_rsp_valid_o}),
    .rsp_rdata_o  (rsp_rdata),
    .rsp_err_o    (rsp_err)
  );

  ctn_ram u_ram (
    .clk_aon,
    .arst_n_i,
    .req_i    (ram_req),
    .we_i     (ram_we),
    .addr_i   (ram_addr),
    .wdata_i  (ram_wdata),
    .be_i     (ram_be),
    .rvalid_o (ram_rvalid),
    .rdata_o  (ram_rdata)
  );

  // Both hosts see the shared response data
  assign h0_rsp_rdata_o = rsp_rdata;
  assign h1_rsp_rdata_o = rsp_rdata;
  assign h0_rsp_err_o   = rsp_err;
  assign h1_rsp_err_o   = rsp_err;

endmodule

//--- rtl/ctn_ram.sv
// Single-port RAM with byte enables, input and output register stages
// Contents clear on reset, rvalid_o follows req_i by two edges
`timescale 1ns/1ps

module ctn_ram (
  input  logic                       clk_aon,
  input  logic                       arst_n_i,
  input  logic                       req_i,
  input  logic                       we_i,
  input  logic [ctn_pkg::SramAw-1:0] addr_i,
  input  logic [ctn_pkg::CtnDw-1:0]  wdata_i,
  input  logic [ctn_pkg::CtnBw-1:0]  be_i,
  output logic                       rvalid_o,
  output logic [ctn_pkg::CtnDw-1:0]  rdata_o
);
  import ctn_pkg::*;

  localparam int Depth = 2 ** SramAw;

  logic [CtnDw-1:0] mem [Depth];

  logic             valid_s1_q;
  logic             valid_s2_q;
  logic [CtnDw-1:0] rdata_s1_q;
  logic [CtnDw-1:0] rdata_s2_q;

  // Input stage, byte-masked write
  always_ff @(posedge clk_aon or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < Depth; i++) begin
        mem[i] <= '0;
      end
      valid_s1_q <= 1'b0;
      valid_s2_q <= 1'b0;
    end else begin
      valid_s1_q <= req_i;
      valid_s2_q <= valid_s1_q; // Output stage
      if (req_i && we_i) begin
        for (int b = 0; b < CtnBw; b++) begin
          if (be_i[b]) begin
            mem[addr_i][8*b +: 8] <= wdata_i[8*b +: 8];
          end
        end
      end
    end
  end

  // Read data path
  always_ff @(posedge clk_aon or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rdata_s1_q <= '0;
      rdata_s2_q <= '0;
    end else begin
      if (req_i && !we_i) begin
        rdata_s1_q <= mem[addr_i];
      end
      rdata_s2_q <= rdata_s1_q;
    end
  end

  assign rvalid_o = valid_s2_q;
  assign rdata_o  = rdata_s2_q;

endmodule

//--- rtl/ctn_sram_adapter.sv
// Window decode and always-granting SRAM adapter, fixed RamLatency responses
// Responses cannot be stalled, so the sideband is a plain shift pipeline
`timescale 1ns/1ps

module ctn_sram_adapter (
  input  logic                          clk_aon,
  input  logic                          arst_n_i,
  // Merged request
  input  logic                          req_i,
  input  logic                          we_i,
  input  ctn_pkg::ctn_addr_u            addr_i,
  input  logic [ctn_pkg::CtnDw-1:0]     wdata_i,
  input  logic [ctn_pkg::CtnBw-1:0]     be_i,
  input  logic                          host_i,
  // RAM side
  output logic                          ram_req_o,
  output logic                          ram_we_o,
  output logic [ctn_pkg::SramAw-1:0]    ram_addr_o,
  output logic [ctn_pkg::CtnDw-1:0]     ram_wdata_o,
  output logic [ctn_pkg::CtnBw-1:0]     ram_be_o,
  input  logic                          ram_rvalid_i,
  input  logic [ctn_pkg::CtnDw-1:0]     ram_rdata_i,
  // Responses
  output logic [ctn_pkg::NumHosts-1:0]  rsp_valid_o,
  output logic [ctn_pkg::CtnDw-1:0]     rsp_rdata_o,
  output logic                          rsp_err_o
);
  import ctn_pkg::*;

  logic hit;

  // Sideband, index 0 is the newest stage
  logic [RamLatency-1:0] sb_valid_q;
  logic [RamLatency-1:0] sb_host_q;
  logic [RamLatency-1:0] sb_we_q;
  logic [RamLatency-1:0] sb_miss_q;

  logic out_valid;
  logic out_read_hit;

  ////////////////////////////////////////
  // Decode and RAM request
  ////////////////////////////////////////

  assign hit = (addr_i.fields.region == RamRegion);

  // Misses never reach the RAM
  assign ram_req_o   = req_i & hit;
  assign ram_we_o    = we_i & hit;
  assign ram_addr_o  = addr_i.fields.idx;
  assign ram_wdata_o = wdata_i;
  assign ram_be_o    = be_i;

  ////////////////////////////////////////
  // Sideband pipeline
  ////////////////////////////////////////

  always_ff @(posedge clk_aon or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sb_valid_q <= '0;
      sb_host_q  <= '0;
      sb_we_q    <= '0;
      sb_miss_q  <= '0;
    end else begin
      sb_valid_q <= {sb_valid_q[RamLatency-2:0], req_i};
      sb_host_q  <= {sb_host_q[RamLatency-2:0], host_i};
      sb_we_q    <= {sb_we_q[RamLatency-2:0], we_i};
      sb_miss_q  <= {sb_miss_q[RamLatency-2:0], ~hit};
    end
  end

  ////////////////////////////////////////
  // Response steering
  ////////////////////////////////////////

  assign out_valid    = sb_valid_q[RamLatency-1];
  assign out_read_hit = ~sb_we_q[RamLatency-1] & ~sb_miss_q[RamLatency-1];

  always_comb begin
    for (int h = 0; h < NumHosts; h++) begin
      rsp_valid_o[h] = out_valid & (sb_host_q[RamLatency-1] == 1'(h));
    end
  end

  assign rsp_err_o   = out_valid & sb_miss_q[RamLatency-1];
  // Writes and misses return zero data
  assign rsp_rdata_o = (out_valid && out_read_hit && ram_rvalid_i) ? ram_rdata_i : '0;

endmodule

//--- rtl/ctn_arbiter.sv
// Two-host round-robin arbiter onto a single request path
// Ready is combinational from valid and only ever raised for the winner
`timescale 1ns/1ps

module ctn_arbiter (
  input  logic                                          clk_aon,
  input  logic                                          arst_n_i,
  input  logic                                          por_n_i,
  // Host side, one lane per host
  input  logic [ctn_pkg::NumHosts-1:0]                  req_valid_i,
  input  logic [ctn_pkg::NumHosts-1:0]                  we_i,
  input  ctn_pkg::ctn_addr_u [ctn_pkg::NumHosts-1:0]    addr_i,
  input  logic [ctn_pkg::NumHosts-1:0][ctn_pkg::CtnDw-1:0] wdata_i,
  input  logic [ctn_pkg::NumHosts-1:0][ctn_pkg::CtnBw-1:0] be_i,
  output logic [ctn_pkg::NumHosts-1:0]                  req_ready_o,
  // Merged request
  output logic                                          req_o,
  output logic                                          we_o,
  output ctn_pkg::ctn_addr_u                            addr_o,
  output logic [ctn_pkg::CtnDw-1:0]                     wdata_o,
  output logic [ctn_pkg::CtnBw-1:0]                     be_o,
  output logic                                          host_o
);
  import ctn_pkg::*;

  logic last_q; // Host accepted last
  logic pick1;

  ////////////////////////////////////////
  // Grant
  ////////////////////////////////////////

  // Host 1 wins when alone, or when both ask and host 0 went last
  assign pick1 = req_valid_i[1] & (~req_valid_i[0] | ~last_q);

  assign req_ready_o[0] = por_n_i & req_valid_i[0] & ~pick1;
  assign req_ready_o[1] = por_n_i & pick1;

  assign req_o  = |req_ready_o;
  assign host_o = pick1;

  always_ff @(posedge clk_aon or negedge arst_n_i) begin
    if (!arst_n_i) begin
      last_q <= 1'b1; // Host 0 goes first
    end else if (req_o) begin
      last_q <= host_o;
    end
  end

  ////////////////////////////////////////
  // Request mux
  ////////////////////////////////////////

  assign we_o    = we_i[host_o];
  assign addr_o  = addr_i[host_o];
  assign wdata_o = wdata_i[host_o];
  assign be_o    = be_i[host_o];

endmodule

//--- rtl/power_on_seq.sv
// Fake platform supply with a dropout, filtered into a power-on-good level
// por_n_o rises 20 clk_aon edges after reset release and never falls again
`timescale 1ns/1ps

module power_on_seq (
  input  logic clk_aon,
  input  logic arst_n_i,
  output logic por_n_o
);
  import ctn_pkg::*;

  logic [PorCntW-1:0] cnt_q;
  logic [PorCntW-1:0] stab_q;
  logic               vcc_supp;
  logic               por_q;

  // Supply pattern: low, short high, low, then high for good
  assign vcc_supp = (cnt_q < 4'h4) ? 1'b0 :
                    (cnt_q < 4'h8) ? 1'b1 :
                    (cnt_q < 4'hc) ? 1'b0 : 1'b1;

  always_ff @(posedge clk_aon or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cnt_q  <= '0;
      stab_q <= '0;
      por_q  <= 1'b0;
    end else begin
      if (cnt_q != '1) begin
        cnt_q <= cnt_q + 1'b1; // Saturates at 15
      end
      if (!vcc_supp) begin
        stab_q <= '0;
      end else if (stab_q != PorCntW'(PorFilterCycles)) begin
        stab_q <= stab_q + 1'b1;
      end
      // Sticky once the supply has been stable long enough
      if (vcc_supp && (stab_q == PorCntW'(PorFilterCycles - 1))) begin
        por_q <= 1'b1;
      end
    end
  end

  assign por_n_o = por_q;

endmodule

//--- rtl/ctn_pkg.sv
// Shared widths and the address map of the CTN memory path
// The RAM window is the 256-word block whose tag is RamRegion
package ctn_pkg;

  ////////////////////////////////////////
  // Widths
  ////////////////////////////////////////

  localparam int CtnAw   = 16;             // CTN word address
  localparam int SramAw  = 8;              // RAM word index, 256 words
  localparam int RegionW = CtnAw - SramAw; // Window tag in the upper bits
  localparam int CtnDw   = 32;
  localparam int CtnBw   = CtnDw / 8;
  localparam int NumHosts = 2;

  ////////////////////////////////////////
  // Address map and timing
  ////////////////////////////////////////

  localparam logic [RegionW-1:0] RamRegion = 8'h40;

  localparam int PorCntW         = 4;
  localparam int PorFilterCycles = 8; // Consecutive high supply samples
  localparam int RamLatency      = 2; // Acceptance to response

  // Raw word address, or tag plus RAM index
  typedef union packed {
    logic [CtnAw-1:0] raw;
    struct packed {
      logic [RegionW-1:0] region;
      logic [SramAw-1:0]  idx;
    } fields;
  } ctn_addr_u;

endpackage
